// ==== rtl/qdrc_consts.svh ====
`ifndef QDRC_CONSTS_SVH
`define QDRC_CONSTS_SVH

// width of one data beat on the sram pins.
`define QDRC_DATA_WIDTH 18

// byte-write enables per beat.
`define QDRC_BW_WIDTH 2

// sram address width.
`define QDRC_ADDR_WIDTH 21

// cycles from read select low to the first returned beat.
`define QDRC_RD_LAT 2

// the top word of the array is kept for calibration.
`define QDRC_CAL_ADDR {`QDRC_ADDR_WIDTH{1'b1}}

// the two halves differ so that swapped beats are caught.
`define QDRC_CAL_PATTERN 36'h9_A5F0_C33C

`endif

// ==== rtl/qdrc_user_pkg.sv ====
`include "qdrc_consts.svh"

package qdrc_user_pkg;

  // one user word carries both beats, low half first.
  typedef logic [2*`QDRC_DATA_WIDTH-1:0] usr_word_t;

  // bits 1:0 belong to the first beat.
  typedef logic [2*`QDRC_BW_WIDTH-1:0] usr_be_t;

  typedef logic [`QDRC_ADDR_WIDTH-1:0] qdr_addr_t;

endpackage

// ==== rtl/qdrc_bus_pkg.sv ====
`include "qdrc_consts.svh"

package qdrc_bus_pkg;

  typedef logic [`QDRC_DATA_WIDTH-1:0] qdr_beat_t;

  // active low on the pins.
  typedef logic [`QDRC_BW_WIDTH-1:0] qdr_bw_t;

  // peer that holds the address and command bus this cycle.
  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_CAL,
    OWN_RD,
    OWN_WR
  } bus_owner_e;

  typedef enum logic [2:0] {
    CAL_IDLE,
    CAL_WRITE,
    CAL_READ,
    CAL_WAIT,
    CAL_DONE,
    CAL_FAIL
  } cal_state_e;

endpackage

// ==== rtl/qdrc_wr.sv ====
`include "qdrc_consts.svh"

module qdrc_wr
  import qdrc_user_pkg::*;
  import qdrc_bus_pkg::*;
(
  input  logic      clk0,
  input  logic      rst_n,
  input  logic      usr_wr_strb,
  input  qdr_addr_t usr_addr,
  input  usr_word_t usr_wr_data,
  input  usr_be_t   usr_wr_be,
  output logic      wr_req,
  output qdr_addr_t wr_addr,
  input  logic      wr_gnt,
  output qdr_beat_t wr_d,
  output qdr_bw_t   wr_bw_n,
  output logic      wr_active
);

  qdr_addr_t addr_q;
  usr_word_t data_q;
  usr_be_t   be_q;
  logic      strb_q;
  logic      beat2_q;
  qdr_beat_t d2_q;
  qdr_bw_t   bw2_n_q;

  // a strobe that saw no grant asks once more in the next cycle.
  assign wr_req  = usr_wr_strb | (strb_q & ~wr_gnt);
  assign wr_addr = usr_wr_strb ? usr_addr : addr_q;

  always_ff @(posedge clk0) begin
    if (!rst_n) begin
      strb_q  <= 1'b0;
      beat2_q <= 1'b0;
    end else begin
      strb_q  <= usr_wr_strb;
      beat2_q <= wr_gnt;
    end
  end

  always_ff @(posedge clk0) begin
    if (usr_wr_strb) begin
      addr_q <= usr_addr;
      data_q <= usr_wr_data;
      be_q   <= usr_wr_be;
    end
    // keep the upper beat apart so a new strobe can reuse the latch.
    if (wr_gnt) begin
      d2_q    <= data_q[2*`QDRC_DATA_WIDTH-1:`QDRC_DATA_WIDTH];
      bw2_n_q <= ~be_q[2*`QDRC_BW_WIDTH-1:`QDRC_BW_WIDTH];
    end
  end

  // first beat in the grant cycle, second beat one cycle later.
  assign wr_d      = beat2_q ? d2_q : data_q[`QDRC_DATA_WIDTH-1:0];
  assign wr_bw_n   = beat2_q ? bw2_n_q : ~be_q[`QDRC_BW_WIDTH-1:0];
  assign wr_active = wr_gnt | beat2_q;

endmodule

// ==== rtl/qdrc_rd.sv ====
module qdrc_rd
  import qdrc_user_pkg::*;
  import qdrc_bus_pkg::*;
(
  input  logic      clk0,
  input  logic      rst_n,
  input  logic      usr_rd_strb,
  input  qdr_addr_t usr_addr,
  output logic      rd_req,
  output qdr_addr_t rd_addr,
  input  logic      rd_gnt,
  input  qdr_beat_t qdr_q,
  input  logic      qdr_qvld,
  output usr_word_t usr_rd_data,
  output logic      usr_rd_dvld
);

  // reads granted whose second beat has not come back yet.
  logic [1:0] pend_cnt;
  logic       beat_hi;
  logic       take;
  logic       last;
  logic       dvld_q;
  qdr_beat_t  lo_q;
  qdr_beat_t  hi_q;

  // reads go straight to the arbiter, which may drop them before phy_rdy.
  assign rd_req  = usr_rd_strb;
  assign rd_addr = usr_addr;

  // beats with no read of ours outstanding belong to calibration.
  assign take = qdr_qvld && (pend_cnt != 2'd0);
  assign last = take && beat_hi;

  always_ff @(posedge clk0) begin
    if (!rst_n) begin
      pend_cnt <= 2'd0;
      beat_hi  <= 1'b0;
      dvld_q   <= 1'b0;
    end else begin
      pend_cnt <= pend_cnt + 2'(rd_gnt) - 2'(last);
      if (take) begin
        beat_hi <= !beat_hi;
      end
      dvld_q <= last;
    end
  end

  always_ff @(posedge clk0) begin
    if (take && !beat_hi) begin
      lo_q <= qdr_q;
    end
    if (last) begin
      hi_q <= qdr_q;
    end
  end

  // the word stays put until the next read's second beat.
  assign usr_rd_data = {hi_q, lo_q};
  assign usr_rd_dvld = dvld_q;

endmodule

// ==== rtl/qdrc_cal.sv ====
`include "qdrc_consts.svh"

module qdrc_cal
  import qdrc_bus_pkg::*;
(
  input  logic      clk0,
  input  logic      rst_n,
  output logic      cal_wr_req,
  output logic      cal_rd_req,
  input  logic      cal_gnt,
  output qdr_beat_t cal_d,
  output logic      cal_wr_active,
  input  qdr_beat_t qdr_q,
  input  logic      qdr_qvld,
  output logic      phy_rdy,
  output logic      cal_fail
);

  // cycles allowed in CAL_WAIT before the read counts as lost.
  localparam int unsigned CAL_TMO = `QDRC_RD_LAT + 6;

  localparam logic [2*`QDRC_DATA_WIDTH-1:0] CAL_PAT = `QDRC_CAL_PATTERN;
  localparam qdr_beat_t PAT_LO = CAL_PAT[`QDRC_DATA_WIDTH-1:0];
  localparam qdr_beat_t PAT_HI = CAL_PAT[2*`QDRC_DATA_WIDTH-1:`QDRC_DATA_WIDTH];

  cal_state_e state;
  cal_state_e state_d;
  logic [3:0] tmr;
  logic       beat_hi;

  always_comb begin
    state_d = state;
    case (state)
      CAL_IDLE:  state_d = CAL_WRITE;
      CAL_WRITE: state_d = CAL_READ;
      // the write must show its grant on the first beat.
      CAL_READ: begin
        if (tmr == 4'd0 && !cal_gnt) begin
          state_d = CAL_FAIL;
        end else if (tmr == 4'd1) begin
          state_d = CAL_WAIT;
        end
      end
      CAL_WAIT: begin
        if (qdr_qvld && !beat_hi) begin
          if (qdr_q != PAT_LO) begin
            state_d = CAL_FAIL;
          end
        end else if (qdr_qvld) begin
          state_d = (qdr_q == PAT_HI) ? CAL_DONE : CAL_FAIL;
        end else if (tmr == 4'(CAL_TMO)) begin
          state_d = CAL_FAIL;
        end
      end
      default: state_d = state;
    endcase
  end

  always_ff @(posedge clk0) begin
    if (!rst_n) begin
      state   <= CAL_IDLE;
      tmr     <= 4'd0;
      beat_hi <= 1'b0;
    end else begin
      state <= state_d;
      if (state_d != state) begin
        tmr <= 4'd0;
      end else if (state == CAL_READ || state == CAL_WAIT) begin
        tmr <= tmr + 4'd1;
      end
      beat_hi <= beat_hi | (state == CAL_WAIT && qdr_qvld);
    end
  end

  assign cal_wr_req = (state == CAL_WRITE);
  // read is asked for during the second write beat, so it follows the write.
  assign cal_rd_req = (state == CAL_READ) && (tmr == 4'd1);

  // CAL_READ spans exactly the two write beats.
  assign cal_wr_active = (state == CAL_READ);
  assign cal_d         = (tmr == 4'd0) ? PAT_LO : PAT_HI;

  assign phy_rdy  = (state == CAL_DONE);
  assign cal_fail = (state == CAL_FAIL);

endmodule

// ==== rtl/qdrc_bus_arb.sv ====
`include "qdrc_consts.svh"

module qdrc_bus_arb
  import qdrc_user_pkg::*;
  import qdrc_bus_pkg::*;
(
  input  logic      clk0,
  input  logic      rst_n,
  input  logic      phy_rdy,
  input  logic      cal_wr_req,
  input  logic      cal_rd_req,
  input  logic      wr_req,
  input  logic      rd_req,
  input  qdr_addr_t wr_addr,
  input  qdr_addr_t rd_addr,
  output logic      cal_gnt,
  output logic      wr_gnt,
  output logic      rd_gnt,
  input  qdr_beat_t cal_d,
  input  logic      cal_wr_active,
  input  qdr_beat_t wr_d,
  input  qdr_bw_t   wr_bw_n,
  input  logic      wr_active,
  output qdr_addr_t qdr_sa,
  output logic      qdr_w_n,
  output logic      qdr_r_n,
  output qdr_beat_t qdr_d,
  output qdr_bw_t   qdr_bw_n,
  output logic      qdr_dll_off_n
);

  bus_owner_e owner;
  logic       wr_busy;
  logic       w_n_q;
  logic       r_n_q;
  logic       cal_gnt_q;
  logic       wr_gnt_q;
  logic       rd_gnt_q;
  logic       dll_q;
  qdr_addr_t  sa_q;

  // a write whose first beat is on the pins still needs the next cycle.
  assign wr_busy = ~w_n_q;

  always_comb begin
    owner = OWN_NONE;
    if (!phy_rdy) begin
      // user requests are dropped until calibration passes.
      if ((cal_wr_req && !wr_busy) || cal_rd_req) begin
        owner = OWN_CAL;
      end
    end else if (rd_req) begin
      owner = OWN_RD;
    end else if (wr_req && !wr_busy) begin
      owner = OWN_WR;
    end
  end

  always_ff @(posedge clk0) begin
    if (!rst_n) begin
      w_n_q     <= 1'b1;
      r_n_q     <= 1'b1;
      cal_gnt_q <= 1'b0;
      wr_gnt_q  <= 1'b0;
      rd_gnt_q  <= 1'b0;
      dll_q     <= 1'b0;
    end else begin
      w_n_q     <= !((owner == OWN_CAL && cal_wr_req) || owner == OWN_WR);
      r_n_q     <= !((owner == OWN_CAL && cal_rd_req) || owner == OWN_RD);
      cal_gnt_q <= (owner == OWN_CAL);
      wr_gnt_q  <= (owner == OWN_WR);
      rd_gnt_q  <= (owner == OWN_RD);
      dll_q     <= 1'b1;
    end
  end

  always_ff @(posedge clk0) begin
    case (owner)
      OWN_CAL: sa_q <= `QDRC_CAL_ADDR;
      OWN_RD:  sa_q <= rd_addr;
      OWN_WR:  sa_q <= wr_addr;
      default: sa_q <= sa_q;
    endcase
  end

  // grants line up with the command on the pins.
  assign cal_gnt = cal_gnt_q;
  assign wr_gnt  = wr_gnt_q;
  assign rd_gnt  = rd_gnt_q;

  assign qdr_sa        = sa_q;
  assign qdr_w_n       = w_n_q;
  assign qdr_r_n       = r_n_q;
  assign qdr_dll_off_n = dll_q;

  // calibration writes the whole word, so every enable is on.
  assign qdr_d    = cal_wr_active ? cal_d : wr_d;
  assign qdr_bw_n = cal_wr_active ? '0 : (wr_active ? wr_bw_n : '1);

endmodule

// ==== rtl/qdr_controller.sv ====
module qdr_controller
  import qdrc_user_pkg::*;
  import qdrc_bus_pkg::*;
(
  input  logic      clk0,
  input  logic      rst_n,
  input  logic      usr_rd_strb,
  input  logic      usr_wr_strb,
  input  qdr_addr_t usr_addr,
  input  usr_word_t usr_wr_data,
  input  usr_be_t   usr_wr_be,
  output usr_word_t usr_rd_data,
  output logic      usr_rd_dvld,
  output logic      phy_rdy,
  output logic      cal_fail,
  output qdr_beat_t qdr_d,
  input  qdr_beat_t qdr_q,
  output qdr_addr_t qdr_sa,
  output logic      qdr_w_n,
  output logic      qdr_r_n,
  output qdr_bw_t   qdr_bw_n,
  output logic      qdr_dll_off_n,
  input  logic      qdr_qvld
);

  logic      wr_req;
  logic      wr_gnt;
  logic      wr_active;
  qdr_addr_t wr_addr;
  qdr_beat_t wr_d;
  qdr_bw_t   wr_bw_n;

  logic      rd_req;
  logic      rd_gnt;
  qdr_addr_t rd_addr;

  logic      cal_wr_req;
  logic      cal_rd_req;
  logic      cal_gnt;
  logic      cal_wr_active;
  qdr_beat_t cal_d;

  qdrc_wr u_wr (
    .clk0        (clk0),
    .rst_n       (rst_n),
    .usr_wr_strb (usr_wr_strb),
    .usr_addr    (usr_addr),
    .usr_wr_data (usr_wr_data),
    .usr_wr_be   (usr_wr_be),
    .wr_req      (wr_req),
    .wr_addr     (wr_addr),
    .wr_gnt      (wr_gnt),
    .wr_d        (wr_d),
    .wr_bw_n     (wr_bw_n),
    .wr_active   (wr_active)
  );

  qdrc_rd u_rd (
    .clk0        (clk0),
    .rst_n       (rst_n),
    .usr_rd_strb (usr_rd_strb),
    .usr_addr    (usr_addr),
    .rd_req      (rd_req),
    .rd_addr     (rd_addr),
    .rd_gnt      (rd_gnt),
    .qdr_q       (qdr_q),
    .qdr_qvld    (qdr_qvld),
    .usr_rd_data (usr_rd_data),
    .usr_rd_dvld (usr_rd_dvld)
  );

  // read beats go to both the read path and calibration.
  qdrc_cal u_cal (
    .clk0          (clk0),
    .rst_n         (rst_n),
    .cal_wr_req    (cal_wr_req),
    .cal_rd_req    (cal_rd_req),
    .cal_gnt       (cal_gnt),
    .cal_d         (cal_d),
    .cal_wr_active (cal_wr_active),
    .qdr_q         (qdr_q),
    .qdr_qvld      (qdr_qvld),
    .phy_rdy       (phy_rdy),
    .cal_fail      (cal_fail)
  );

  qdrc_bus_arb u_arb (
    .clk0          (clk0),
    .rst_n         (rst_n),
    .phy_rdy       (phy_rdy),
    .cal_wr_req    (cal_wr_req),
    .cal_rd_req    (cal_rd_req),
    .wr_req        (wr_req),
    .rd_req        (rd_req),
    .wr_addr       (wr_addr),
    .rd_addr       (rd_addr),
    .cal_gnt       (cal_gnt),
    .wr_gnt        (wr_gnt),
    .rd_gnt        (rd_gnt),
    .cal_d         (cal_d),
    .cal_wr_active (cal_wr_active),
    .wr_d          (wr_d),
    .wr_bw_n       (wr_bw_n),
    .wr_active     (wr_active),
    .qdr_sa        (qdr_sa),
    .qdr_w_n       (qdr_w_n),
    .qdr_r_n       (qdr_r_n),
    .qdr_d         (qdr_d),
    .qdr_bw_n      (qdr_bw_n),
    .qdr_dll_off_n (qdr_dll_off_n)
  );

endmodule

// ==== tb/qdr_sram_model.sv ====
`include "qdrc_consts.svh"

module qdr_sram_model
  import qdrc_user_pkg::*;
  import qdrc_bus_pkg::*;
(
  input  logic      clk0,
  input  logic      rst_n,
  input  qdr_addr_t qdr_sa,
  input  logic      qdr_w_n,
  input  logic      qdr_r_n,
  input  qdr_beat_t qdr_d,
  input  qdr_bw_t   qdr_bw_n,
  output qdr_beat_t qdr_q,
  output logic      qdr_qvld
);

  localparam int LAT = `QDRC_RD_LAT;
  localparam int LANE = `QDRC_DATA_WIDTH / `QDRC_BW_WIDTH;

  usr_word_t mem [qdr_addr_t];

  logic      wr_pend;
  qdr_addr_t wr_addr_q;
  qdr_beat_t wr_lo_q;
  logic      pipe_v [LAT];
  usr_word_t pipe_w [LAT];
  logic      hi_v;
  qdr_beat_t hi_q;

  // unwritten words read back as a fill built from the full address.
  function automatic usr_word_t fetch(qdr_addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {15'h7E01, a};
  endfunction

  function automatic qdr_beat_t merge(qdr_beat_t old, qdr_beat_t nw, qdr_bw_t bw_n);
    qdr_beat_t res;
    res = old;
    for (int i = 0; i < `QDRC_BW_WIDTH; i++) begin
      if (!bw_n[i]) begin
        res[i*LANE +: LANE] = nw[i*LANE +: LANE];
      end
    end
    return res;
  endfunction

  always @(posedge clk0) begin
    usr_word_t word;
    if (!rst_n) begin
      wr_pend <= 1'b0;
      hi_v    <= 1'b0;
      for (int i = 0; i < LAT; i++) begin
        pipe_v[i] <= 1'b0;
      end
    end else begin
      // the second write beat commits before any read looks up the array.
      if (wr_pend) begin
        word = fetch(wr_addr_q);
        word[2*`QDRC_DATA_WIDTH-1:`QDRC_DATA_WIDTH] =
          merge(word[2*`QDRC_DATA_WIDTH-1:`QDRC_DATA_WIDTH], qdr_d, qdr_bw_n);
        word[`QDRC_DATA_WIDTH-1:0] = wr_lo_q;
        mem[wr_addr_q] = word;
      end
      wr_pend <= !qdr_w_n;
      if (!qdr_w_n) begin
        word = fetch(qdr_sa);
        wr_addr_q <= qdr_sa;
        wr_lo_q   <= merge(word[`QDRC_DATA_WIDTH-1:0], qdr_d, qdr_bw_n);
      end
      pipe_v[0] <= !qdr_r_n;
      pipe_w[0] <= fetch(qdr_sa);
      for (int i = 1; i < LAT; i++) begin
        pipe_v[i] <= pipe_v[i-1];
        pipe_w[i] <= pipe_w[i-1];
      end
      hi_v <= pipe_v[LAT-1];
      hi_q <= pipe_w[LAT-1][2*`QDRC_DATA_WIDTH-1:`QDRC_DATA_WIDTH];
    end
  end

  assign qdr_qvld = pipe_v[LAT-1] | hi_v;
  assign qdr_q    = pipe_v[LAT-1] ? pipe_w[LAT-1][`QDRC_DATA_WIDTH-1:0] : hi_q;

endmodule

// ==== tb/qdr_controller_asserts.sv ====
module qdr_controller_asserts (
  input logic clk0,
  input logic rst_n,
  input logic qdr_w_n,
  input logic qdr_r_n,
  input logic phy_rdy,
  input logic usr_rd_dvld
);

  // user reads put on the pins whose word has not been returned yet.
  logic [2:0] rd_open;

  always @(posedge clk0) begin
    if (!rst_n) begin
      rd_open <= '0;
    end else begin
      rd_open <= rd_open + 3'(!qdr_r_n && phy_rdy) - 3'(usr_rd_dvld);
    end
  end

  // selects settle high one cycle into reset.
  a_rst_idle: assert property (@(posedge clk0) !rst_n |=> (qdr_w_n && qdr_r_n))
    else $error("selects not idle during reset");

  // calibration never issues a read and a write together.
  a_no_dual_sel: assert property (@(posedge clk0) disable iff (!rst_n)
    !(!qdr_w_n && !qdr_r_n && !phy_rdy))
    else $error("read and write select low together before phy_rdy");

  a_dvld_after_rd: assert property (@(posedge clk0) disable iff (!rst_n)
    usr_rd_dvld |-> (rd_open != 3'd0))
    else $error("read data valid with no user read select outstanding");

endmodule

bind qdr_controller qdr_controller_asserts u_asserts (
  .clk0        (clk0),
  .rst_n       (rst_n),
  .qdr_w_n     (qdr_w_n),
  .qdr_r_n     (qdr_r_n),
  .phy_rdy     (phy_rdy),
  .usr_rd_dvld (usr_rd_dvld)
);

// ==== tb/tb_qdr_controller.sv ====
module tb_qdr_controller
  import qdrc_user_pkg::*;
  import qdrc_bus_pkg::*;
();

  logic      clk0;
  logic      rst_n;
  logic      usr_rd_strb;
  logic      usr_wr_strb;
  qdr_addr_t usr_addr;
  usr_word_t usr_wr_data;
  usr_be_t   usr_wr_be;
  usr_word_t usr_rd_data;
  logic      usr_rd_dvld;
  logic      phy_rdy;
  logic      cal_fail;
  qdr_beat_t qdr_d;
  qdr_beat_t qdr_q;
  qdr_addr_t qdr_sa;
  logic      qdr_w_n;
  logic      qdr_r_n;
  qdr_bw_t   qdr_bw_n;
  logic      qdr_dll_off_n;
  logic      qdr_qvld;

  byte       op_a   [$];
  qdr_addr_t addr_a [$];
  usr_word_t data_a [$];
  usr_be_t   be_a   [$];
  usr_word_t exp_a  [$];
  usr_word_t exp_q  [$];
  int        line_q [$];
  int        cyc;
  int        limit;

  qdr_controller u_dut (.*);

  qdr_sram_model u_sram (.*);

  always #50 clk0 = ~clk0;

  task automatic fail_run();
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_word(string name, usr_word_t exp, usr_word_t act);
    assert (exp === act) else begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic load_trace();
    int fd;
    int n;
    string line;
    string op;
    qdr_addr_t a;
    usr_word_t d;
    usr_be_t b;
    usr_word_t e;
    fd = $fopen("tb/qdr_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file tb/qdr_trace.txt");
      fail_run();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // comment and blank lines carry no operation.
      if (n > 1 && line[0] != "#") begin
        n = $sscanf(line, "%s %h %h %h %h", op, a, d, b, e);
        op_a.push_back(op[0]);
        addr_a.push_back(a);
        data_a.push_back(d);
        be_a.push_back(b);
        exp_a.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  task automatic run_op(int i);
    usr_addr    = addr_a[i];
    usr_wr_data = data_a[i];
    usr_wr_be   = be_a[i];
    case (op_a[i])
      "W": usr_wr_strb = 1'b1;
      "R": usr_rd_strb = 1'b1;
      "C": begin
        usr_wr_strb = 1'b1;
        usr_rd_strb = 1'b1;
      end
      "I": repeat (int'(addr_a[i])) @(negedge clk0);
      "P": begin
        while (!phy_rdy && !cal_fail) @(negedge clk0);
        check_word("calibration", 36'h1, {35'h0, phy_rdy && !cal_fail});
        check_word("dll on after reset", 36'h1, {35'h0, qdr_dll_off_n});
      end
      default: begin
        $display("unknown operation in trace line %0d", i);
        fail_run();
      end
    endcase
    if (op_a[i] == "R" || op_a[i] == "C") begin
      exp_q.push_back(exp_a[i]);
      line_q.push_back(i);
    end
    if (op_a[i] == "W" || op_a[i] == "R" || op_a[i] == "C") begin
      @(negedge clk0);
      usr_wr_strb = 1'b0;
      usr_rd_strb = 1'b0;
    end
  endtask

  // read words are compared in issue order.
  always @(negedge clk0) begin
    if (rst_n && usr_rd_dvld) begin
      if (exp_q.size() == 0) begin
        $display("read data returned with no read outstanding");
        fail_run();
      end else begin
        check_word($sformatf("trace op %0d read", line_q.pop_front()),
                   exp_q.pop_front(), usr_rd_data);
      end
    end
  end

  always @(posedge clk0) begin
    cyc <= cyc + 1;
    if (limit > 0 && cyc > limit) begin
      $display("timeout after %0d cycles", cyc);
      fail_run();
    end
  end

  initial begin
    clk0        = 1'b0;
    rst_n       = 1'b0;
    usr_rd_strb = 1'b0;
    usr_wr_strb = 1'b0;
    usr_addr    = '0;
    usr_wr_data = '0;
    usr_wr_be   = '0;
    cyc         = 0;
    limit       = 0;
    load_trace();
    limit = 40 * op_a.size() + 200;
    repeat (16) @(negedge clk0);
    check_word("dll off in reset", 36'h0, {35'h0, qdr_dll_off_n});
    rst_n = 1'b1;
    for (int i = 0; i < op_a.size(); i++) begin
      run_op(i);
    end
    while (exp_q.size() != 0) @(negedge clk0);
    repeat (4) @(negedge clk0);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== tb/qdr_trace.txt ====
# columns: op addr(hex) wdata(hex) be(hex) expected(hex)
# op W write, R read, C read+write one cycle, I idle (addr = count), P wait for phy_rdy
W 000010 123456789 f 000000000
P 000000 000000000 0 000000000
R 000010 000000000 0 fc0200010
I 000006 000000000 0 000000000
R 1fffff 000000000 0 9a5f0c33c
I 000006 000000000 0 000000000
W 000020 0abcdef01 f 000000000
I 000003 000000000 0 000000000
R 000020 000000000 0 0abcdef01
I 000006 000000000 0 000000000
W 000020 fffffffff 5 000000000
I 000003 000000000 0 000000000
R 000020 000000000 0 0affdefff
I 000006 000000000 0 000000000
W 000030 111111111 f 000000000
I 000006 000000000 0 000000000
C 000030 222222222 f 111111111
I 000001 000000000 0 000000000
R 000030 000000000 0 222222222
I 000006 000000000 0 000000000
W 000040 0c0ffee01 f 000000000
I 000003 000000000 0 000000000
W 000050 076543210 f 000000000
I 000003 000000000 0 000000000
R 000040 000000000 0 0c0ffee01
I 000001 000000000 0 000000000
R 000050 000000000 0 076543210
I 000001 000000000 0 000000000
R 000123 000000000 0 fc0200123

// ==== sources.f ====
+incdir+rtl
rtl/qdrc_user_pkg.sv
rtl/qdrc_bus_pkg.sv
rtl/qdrc_wr.sv
rtl/qdrc_rd.sv
rtl/qdrc_cal.sv
rtl/qdrc_bus_arb.sv
rtl/qdr_controller.sv
tb/qdr_sram_model.sv
tb/qdr_controller_asserts.sv
tb/tb_qdr_controller.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_qdr_controller
FILELIST  := sources.f
FLAGS     := --timing --assert
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
